//--- hdl/stopwatch_pkg.sv
`default_nettype none

package stopwatch_pkg;

  // one decimal digit.
  typedef logic [3:0] bcd_t;

  // active-low segments, bit 0 is a, bit 6 is g.
  typedef logic [6:0] seg7_t;

  // edit cursor: 0 is no edit, 1..4 select hundredths up to tens of seconds.
  typedef logic [2:0] digit_sel_t;

  localparam int unsigned NUM_DIGITS = 4;

  localparam bcd_t BCD_MAX = 4'd9;

  localparam digit_sel_t SEL_NONE = 3'd0;
  localparam digit_sel_t SEL_LAST = 3'd4;

  // 100 MHz / 1_000_000 gives one tick per hundredth of a second.
  localparam int unsigned TICK_CYCLES_DEF = 1_000_000;

  // about 10 ms of stable press.
  localparam int unsigned DEBOUNCE_CYCLES_DEF = 1_000_000;

  localparam int unsigned DEBOUNCE_W = 20;
  localparam int unsigned TICK_W = 20;

endpackage

`default_nettype wire

//--- hdl/time_ctrl_if.sv
`timescale 1ns/1ps
`default_nettype none

interface time_ctrl_if import stopwatch_pkg::*; ();

  logic       running;   // level, set by control.
  logic       tick;      // one hundredth has passed.
  digit_sel_t edit_sel;  // digit under the edit cursor.
  logic       edit_inc;  // bump the selected digit.

  modport ctrl_mp (
    output running,
    output edit_sel,
    output edit_inc
  );

  modport div_mp (
    input  running,
    output tick
  );

  modport cnt_mp (
    input tick,
    input edit_sel,
    input edit_inc
  );

endinterface

`default_nettype wire

//--- hdl/button_debouncer.sv
`timescale 1ns/1ps
`default_nettype none

module button_debouncer import stopwatch_pkg::*; #(
  parameter int unsigned debounce_cycles = DEBOUNCE_CYCLES_DEF
) (
  input  logic clk100_i,
  input  logic rstn_i,
  input  logic btn_n_i,
  output logic press_o
);

  logic                  sync0_n;
  logic                  sync1_n;
  logic [DEBOUNCE_W-1:0] stable_cnt;

  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      sync0_n <= 1'b1;
      sync1_n <= 1'b1;
    end else begin
      sync0_n <= btn_n_i;
      sync1_n <= sync0_n;
    end
  end

  // counts while held, parks at the limit until release.
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      stable_cnt <= '0;
      press_o    <= 1'b0;
    end else begin
      if (sync1_n) begin
        stable_cnt <= '0;
      end else if (stable_cnt != DEBOUNCE_W'(debounce_cycles)) begin
        stable_cnt <= stable_cnt + 1'b1;
      end
      press_o <= !sync1_n && (stable_cnt == DEBOUNCE_W'(debounce_cycles - 1));
    end
  end

endmodule

`default_nettype wire

//--- hdl/tick_divider.sv
`timescale 1ns/1ps
`default_nettype none

module tick_divider import stopwatch_pkg::*; #(
  parameter int unsigned tick_cycles = TICK_CYCLES_DEF
) (
  input  logic        clk100_i,
  input  logic        rstn_i,
  time_ctrl_if.div_mp tc
);

  logic [TICK_W-1:0] div_cnt;
  logic              wrap;

  assign wrap    = (div_cnt == TICK_W'(tick_cycles - 1));
  assign tc.tick = tc.running && wrap;

  // residue is kept across a stop.
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      div_cnt <= '0;
    end else if (tc.running) begin
      if (wrap) begin
        div_cnt <= '0;
      end else begin
        div_cnt <= div_cnt + 1'b1;
      end
    end
  end

endmodule

`default_nettype wire

//--- hdl/stopwatch_ctrl.sv
`timescale 1ns/1ps
`default_nettype none

module stopwatch_ctrl import stopwatch_pkg::*; (
  input  logic         clk100_i,
  input  logic         rstn_i,
  input  logic         start_stop_i,
  input  logic         set_i,
  input  logic         change_i,
  time_ctrl_if.ctrl_mp tc
);

  logic editing;

  assign editing = (tc.edit_sel != SEL_NONE);

  // run flag, a start is refused while a digit is selected.
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      tc.running <= 1'b0;
    end else if (start_stop_i) begin
      if (tc.running) begin
        tc.running <= 1'b0;
      end else if (!editing) begin
        tc.running <= 1'b1;
      end
    end
  end

  // edit cursor walks 1..4 and back to none.
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      tc.edit_sel <= SEL_NONE;
    end else if (set_i && !tc.running) begin
      if (tc.edit_sel == SEL_LAST) begin
        tc.edit_sel <= SEL_NONE;
      end else begin
        tc.edit_sel <= tc.edit_sel + 1'b1;
      end
    end
  end

  // a change in the same cycle as set is dropped.
  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      tc.edit_inc <= 1'b0;
    end else begin
      tc.edit_inc <= change_i && !set_i && !tc.running && editing;
    end
  end

endmodule

`default_nettype wire

//--- hdl/bcd_time_counter.sv
`timescale 1ns/1ps
`default_nettype none

module bcd_time_counter import stopwatch_pkg::*; (
  input  logic                  clk100_i,
  input  logic                  rstn_i,
  time_ctrl_if.cnt_mp           tc,
  output bcd_t [NUM_DIGITS-1:0] digits_o
);

  bcd_t [NUM_DIGITS-1:0] digit_q;
  logic [NUM_DIGITS-1:0] adv;

  function automatic bcd_t next_digit(input bcd_t d);
    if (d == BCD_MAX) begin
      return '0;
    end
    return d + 1'b1;
  endfunction

  // ripple carry from the tick, or a single edited digit.
  always_comb begin : adv_logic
    logic carry;
    carry = tc.tick;
    for (int i = 0; i < NUM_DIGITS; i++) begin
      adv[i] = carry || (tc.edit_inc && (tc.edit_sel == digit_sel_t'(i + 1)));
      carry  = carry && (digit_q[i] == BCD_MAX);
    end
  end

  always_ff @(posedge clk100_i or negedge rstn_i) begin
    if (!rstn_i) begin
      digit_q <= '0;
    end else begin
      for (int i = 0; i < NUM_DIGITS; i++) begin
        if (adv[i]) begin
          digit_q[i] <= next_digit(digit_q[i]);
        end
      end
    end
  end

  assign digits_o = digit_q;

endmodule

`default_nettype wire

//--- hdl/seg7_decoder.sv
`timescale 1ns/1ps
`default_nettype none

module seg7_decoder import stopwatch_pkg::*; (
  input  bcd_t  digit_i,
  output seg7_t seg_o
);

  always_comb begin
    case (digit_i)
      4'd0:    seg_o = 7'h40;
      4'd1:    seg_o = 7'h79;
      4'd2:    seg_o = 7'h24;
      4'd3:    seg_o = 7'h30;
      4'd4:    seg_o = 7'h19;
      4'd5:    seg_o = 7'h12;
      4'd6:    seg_o = 7'h02;
      4'd7:    seg_o = 7'h78;
      4'd8:    seg_o = 7'h00;
      4'd9:    seg_o = 7'h10;
      default: seg_o = 7'h3F;  // dash, only g lit.
    endcase
  end

endmodule

`default_nettype wire

//--- hdl/stopwatch_top.sv
`timescale 1ns/1ps
`default_nettype none

module stopwatch_top import stopwatch_pkg::*; #(
  parameter int unsigned tick_cycles     = TICK_CYCLES_DEF,
  parameter int unsigned debounce_cycles = DEBOUNCE_CYCLES_DEF
) (
  input  logic  clk100_i,
  input  logic  rstn_i,
  input  logic  start_stop_i,
  input  logic  set_i,
  input  logic  change_i,
  output seg7_t hex0_o,
  output seg7_t hex1_o,
  output seg7_t hex2_o,
  output seg7_t hex3_o,
  output logic  running_o
);

  logic                  start_stop_press;
  logic                  set_press;
  logic                  change_press;
  bcd_t [NUM_DIGITS-1:0] digits;

  time_ctrl_if tc ();

  button_debouncer #(.debounce_cycles(debounce_cycles)) start_stop_deb_inst (
    .clk100_i(clk100_i), .rstn_i(rstn_i), .btn_n_i(start_stop_i), .press_o(start_stop_press)
  );
  button_debouncer #(.debounce_cycles(debounce_cycles)) set_deb_inst (
    .clk100_i(clk100_i), .rstn_i(rstn_i), .btn_n_i(set_i), .press_o(set_press)
  );
  button_debouncer #(.debounce_cycles(debounce_cycles)) change_deb_inst (
    .clk100_i(clk100_i), .rstn_i(rstn_i), .btn_n_i(change_i), .press_o(change_press)
  );

  stopwatch_ctrl ctrl_inst (
    .clk100_i(clk100_i), .rstn_i(rstn_i), .start_stop_i(start_stop_press),
    .set_i(set_press), .change_i(change_press), .tc(tc.ctrl_mp)
  );

  tick_divider #(.tick_cycles(tick_cycles)) divider_inst (
    .clk100_i(clk100_i), .rstn_i(rstn_i), .tc(tc.div_mp)
  );

  bcd_time_counter counter_inst (
    .clk100_i(clk100_i), .rstn_i(rstn_i), .tc(tc.cnt_mp), .digits_o(digits)
  );

  // hex0 is hundredths, hex3 tens of seconds.
  seg7_decoder hex0_dec_inst (.digit_i(digits[0]), .seg_o(hex0_o));
  seg7_decoder hex1_dec_inst (.digit_i(digits[1]), .seg_o(hex1_o));
  seg7_decoder hex2_dec_inst (.digit_i(digits[2]), .seg_o(hex2_o));
  seg7_decoder hex3_dec_inst (.digit_i(digits[3]), .seg_o(hex3_o));

  assign running_o = tc.running;

endmodule

`default_nettype wire

//--- verification/stopwatch_properties.sv
`timescale 1ns/1ps
`default_nettype none

module stopwatch_properties import stopwatch_pkg::*; (
  input logic                  clk100_i,
  input logic                  rstn_i,
  input logic                  tick_i,
  input logic                  edit_inc_i,
  input bcd_t [NUM_DIGITS-1:0] digits_i
);

  int fail_count = 0;  // failed assertions so far.

  digits_bcd_a: assert property (@(posedge clk100_i) disable iff (!rstn_i)
    (digits_i[0] <= BCD_MAX) && (digits_i[1] <= BCD_MAX) &&
    (digits_i[2] <= BCD_MAX) && (digits_i[3] <= BCD_MAX))
    else begin
      fail_count++;
      $error("digit outside 0..9: %h", digits_i);
    end

  // digits move only on a tick or an edit.
  digits_hold_a: assert property (@(posedge clk100_i) disable iff (!rstn_i)
    (!tick_i && !edit_inc_i) |=> $stable(digits_i))
    else begin
      fail_count++;
      $error("digits changed without tick or edit_inc");
    end

  tick_edit_excl_a: assert property (@(posedge clk100_i) disable iff (!rstn_i)
    !(tick_i && edit_inc_i))
    else begin
      fail_count++;
      $error("tick and edit_inc high together");
    end

endmodule

bind bcd_time_counter stopwatch_properties counter_props_inst (
  .clk100_i(clk100_i),
  .rstn_i(rstn_i),
  .tick_i(tc.tick),
  .edit_inc_i(tc.edit_inc),
  .digits_i(digits_o)
);

`default_nettype wire

//--- verification/stopwatch_tb.sv
`timescale 1ns/1ps
`default_nettype none

module stopwatch_tb import stopwatch_pkg::*; ();

  localparam string STIM_FILE  = "verification/stopwatch_input.txt";
  localparam int    CLK_PERIOD = 8;
  localparam int    PRESS_LOW  = 6;
  localparam int    PRESS_HIGH = 6;

  logic  clk100;
  logic  rstn;
  logic  start_stop_n;
  logic  set_n;
  logic  change_n;
  seg7_t hex [4];
  logic  running;
  int    budget_cycles = 0;

  stopwatch_top #(.tick_cycles(20), .debounce_cycles(4)) stopwatch_top_inst (
    .clk100_i(clk100), .rstn_i(rstn), .start_stop_i(start_stop_n), .set_i(set_n),
    .change_i(change_n), .hex0_o(hex[0]), .hex1_o(hex[1]), .hex2_o(hex[2]),
    .hex3_o(hex[3]), .running_o(running)
  );

  initial begin
    clk100 = 1'b0;
    forever #(CLK_PERIOD / 2) clk100 = ~clk100;
  end

  task automatic abort_run();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped on the first failure");
  endtask

  // each lit segment clears its bit in the active-low pattern.
  function automatic seg7_t expected_seg(input int digit);
    string lit;
    seg7_t pattern;
    case (digit)
      0: lit = "abcdef";
      1: lit = "bc";
      2: lit = "abdeg";
      3: lit = "abcdg";
      4: lit = "bcfg";
      5: lit = "acdfg";
      6: lit = "acdefg";
      7: lit = "abc";
      8: lit = "abcdefg";
      9: lit = "abcdfg";
      default: lit = "g";
    endcase
    pattern = '1;
    for (int i = 0; i < lit.len(); i++) begin
      pattern &= ~(seg7_t'(1) << (lit.getc(i) - "a"));
    end
    return pattern;
  endfunction

  task automatic check_seg(input int idx, input seg7_t got, input seg7_t exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: hex%0d_o is %h, expected %h", $time, idx, got, exp);
      abort_run();
    end
  endtask

  task automatic check_running(input logic got, input logic exp);
    if (got !== exp) begin
      $display("[ERROR] %0t: running_o is %b, expected %b", $time, got, exp);
      abort_run();
    end
  endtask

  task automatic drive_button(input string name, input logic level);
    case (name)
      "start":  start_stop_n = level;
      "set":    set_n = level;
      "change": change_n = level;
      default: begin
        $display("unknown button name '%s' in the stimulus file", name);
        abort_run();
      end
    endcase
  endtask

  task automatic press_button(input string name);
    drive_button(name, 1'b0);
    repeat (PRESS_LOW) @(posedge clk100);
    #1;
    drive_button(name, 1'b1);
    repeat (PRESS_HIGH) @(posedge clk100);
    #1;
  endtask

  // waits plus press lengths plus some margin.
  function automatic int count_budget();
    int    fd;
    int    n;
    int    cycles;
    int    arg;
    string line;
    string cmd;
    cycles = 100;
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      return 0;
    end
    while (!$feof(fd)) begin
      line = "";
      cmd  = "";
      n = $fgets(line, fd);
      n = $sscanf(line, "%s %d", cmd, arg);
      if (cmd == "press") begin
        cycles += PRESS_LOW + PRESS_HIGH;
      end else if (cmd == "wait" && n == 2) begin
        cycles += arg;
      end
    end
    $fclose(fd);
    return cycles;
  endfunction

  initial begin : watchdog
    wait (budget_cycles != 0);
    #(budget_cycles * CLK_PERIOD);
    $display("watchdog expired after %0d cycles before the stimulus ended", budget_cycles);
    abort_run();
  end

  // a bound counter assertion ends the run at its first failure.
  initial begin : assertion_watch
    wait (stopwatch_top_inst.counter_inst.counter_props_inst.fail_count != 0);
    $display("a counter assertion failed, see the error above");
    abort_run();
  end

  initial begin : stimulus
    int    fd;
    int    n;
    int    wait_cycles;
    int    exp_digit [4];
    int    exp_run;
    string line;
    string cmd;
    string arg;
    rstn         = 1'b0;
    start_stop_n = 1'b1;
    set_n        = 1'b1;
    change_n     = 1'b1;
    budget_cycles = count_budget();
    fd = $fopen(STIM_FILE, "r");
    if (fd == 0) begin
      $display("cannot open the stimulus file %s", STIM_FILE);
      abort_run();
    end
    repeat (10) @(posedge clk100);
    #1;
    rstn = 1'b1;
    while (!$feof(fd)) begin
      line = "";
      cmd  = "";
      n = $fgets(line, fd);
      if (line.len() == 0 || line.getc(0) == "#") begin
        continue;
      end
      n = $sscanf(line, "%s", cmd);
      case (cmd)
        "": ;  // blank line.
        "press": begin
          n = $sscanf(line, "%s %s", cmd, arg);
          press_button(arg);
        end
        "wait": begin
          n = $sscanf(line, "%s %d", cmd, wait_cycles);
          if (n != 2) begin
            $display("wait line without a cycle count: %s", line);
            abort_run();
          end
          repeat (wait_cycles) @(posedge clk100);
          #1;
        end
        "expect": begin
          n = $sscanf(line, "%s %d %d %d %d %d", cmd, exp_digit[3], exp_digit[2],
                      exp_digit[1], exp_digit[0], exp_run);
          if (n != 6) begin
            $display("expect line without four digits and a run bit: %s", line);
            abort_run();
          end
          for (int i = 0; i < 4; i++) begin
            check_seg(i, hex[i], expected_seg(exp_digit[i]));
          end
          check_running(running, exp_run != 0);
        end
        default: begin
          $display("unknown command '%s' in the stimulus file", cmd);
          abort_run();
        end
      endcase
    end
    $fclose(fd);
    if (stopwatch_top_inst.counter_inst.counter_props_inst.fail_count == 0) begin
      $display("Result: PASSED");
      $finish;
    end else begin
      $display("%0d counter assertion failures",
               stopwatch_top_inst.counter_inst.counter_props_inst.fail_count);
      abort_run();
    end
  end

endmodule

`default_nettype wire

//--- verilog.f
hdl/stopwatch_pkg.sv
hdl/time_ctrl_if.sv
hdl/button_debouncer.sv
hdl/tick_divider.sv
hdl/stopwatch_ctrl.sv
hdl/bcd_time_counter.sv
hdl/seg7_decoder.sv
hdl/stopwatch_top.sv
verification/stopwatch_properties.sv
verification/stopwatch_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary --assert -j 0 --top-module stopwatch_tb -f verilog.f -o stopwatch_sim
./obj_dir/stopwatch_sim +verilator+error+limit+1000 | tee sim.log

if grep -q "Result: FAILED" sim.log; then
  echo "simulation failed, see sim.log"
  exit 1
fi
if ! grep -q "Result: PASSED" sim.log; then
  echo "simulation ended without a result, see sim.log"
  exit 1
fi

//--- verification/stopwatch_input.txt
# press <start|set|change> | wait <cycles>
# expect <tens> <seconds> <tenths> <hundredths> <running>
expect 0 0 0 0 0
press start
expect 0 0 0 0 1
wait 60
press start
expect 0 0 0 3 0
press start
expect 0 0 0 3 1
wait 2000
press start
expect 0 1 0 4 0
press set
press change
press change
press change
press change
press change
press change
expect 0 1 0 0 0
press set
press change
press start
expect 0 1 1 0 0
press set
press set
press set
press change
expect 0 1 1 0 0
press start
expect 0 1 1 0 1
press set
expect 0 1 1 1 1
press start
press change
expect 0 1 1 1 0
